// File: include/sw_cfg.svh
// Smith-Waterman engine configuration: sequence lengths, score width and scoring constants
`ifndef SW_CFG_SVH
`define SW_CFG_SVH

// Sequence lengths
// The reference length is also the number of PEs
`define SW_REF_LEN      16
`define SW_QUERY_LEN    24

// Signed score width
`define SW_SCORE_W      8

// Scoring constants
// Mismatch is signed, gap costs are subtracted
`define SW_MATCH        2
`define SW_MISMATCH     (-1)
`define SW_GAP_OPEN     2
`define SW_GAP_EXTEND   1

// Input valid edge to the edge where finish is seen high
`define SW_LATENCY      ((`SW_QUERY_LEN) + 2 * (`SW_REF_LEN) + 2)

`endif

// File: source/sw_pkg.sv
// Smith-Waterman shared types: bases, scores, positions and the run states
`include "sw_cfg.svh"

package sw_pkg;

    // 2-bit nucleotide code
    typedef logic [1:0] base_t;

    // Alignment, insert and delete scores
    typedef logic signed [`SW_SCORE_W-1:0] score_t;

    // Zero-based positions inside the design
    typedef logic [$clog2(`SW_REF_LEN)-1:0] ref_idx_t;
    typedef logic [$clog2(`SW_QUERY_LEN)-1:0] query_idx_t;

    // Run sequencing
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        DRAIN,
        SCAN,
        DONE
    } seq_state_t;

endpackage

// File: source/sw_feed_if.sv
// Feed bundle carrying query bases, reference bank and run clear into the PE array
`timescale 1ns/1ps
`include "sw_cfg.svh"

interface sw_feed_if;

    // Query row entering PE 0
    logic               feed_valid;
    sw_pkg::base_t      query_base;
    sw_pkg::query_idx_t query_idx;

    // One reference base per PE
    sw_pkg::base_t      ref_bases [`SW_REF_LEN];

    // Run start, loads boundary values into the cells
    logic               clear;

    modport sequencer (
        output feed_valid, query_base, query_idx, ref_bases, clear
    );

    modport array (
        input  feed_valid, query_base, query_idx, ref_bases, clear
    );

endinterface

// File: source/sw_score_if.sv
// Score bundle carrying per-PE alignment scores and query indices to the max tracker
`timescale 1ns/1ps
`include "sw_cfg.svh"

interface sw_score_if;

    // Registered cell outputs, one entry per PE
    sw_pkg::score_t     align     [`SW_REF_LEN];
    logic               valid     [`SW_REF_LEN];
    sw_pkg::query_idx_t query_idx [`SW_REF_LEN];

    modport array (
        output align, valid, query_idx
    );

    modport tracker (
        input  align, valid, query_idx
    );

endinterface

// File: source/sw_sequencer.sv
// Run sequencer: FSM, input capture, reference bank and query feed for the PE array
`timescale 1ns/1ps
`include "sw_cfg.svh"

module sw_sequencer (
    input  logic          clk,
    input  logic          reset,
    input  logic          i_valid,
    input  sw_pkg::base_t i_ref_base,
    input  sw_pkg::base_t i_query_base,
    sw_feed_if.sequencer  i_feed,
    output logic          o_clear,
    output logic          o_scan,
    output logic          o_finish
);

    localparam int CNT_W      = $clog2(`SW_LATENCY + 1);
    localparam int LOAD_LAST  = `SW_QUERY_LEN - 1;
    // Last cell result reaches the tracker one cycle after the array drains
    localparam int DRAIN_LAST = `SW_QUERY_LEN + `SW_REF_LEN + 1;
    localparam int SCAN_LAST  = DRAIN_LAST + `SW_REF_LEN;

    sw_pkg::seq_state_t state;
    logic [CNT_W-1:0]   cnt;
    logic               start;
    logic               capture;
    logic               cap_valid;
    logic               feed_valid;
    logic               clear;
    sw_pkg::base_t      cap_query;
    sw_pkg::base_t      feed_query;
    sw_pkg::query_idx_t cap_idx;
    sw_pkg::query_idx_t feed_idx;
    sw_pkg::base_t      ref_bank [`SW_REF_LEN];

    assign start   = i_valid && (state == sw_pkg::IDLE || state == sw_pkg::DONE);
    assign capture = start || (state == sw_pkg::LOAD);

    // ------------------------------------------------------------------
    // Run FSM, cnt equals cycles since the start edge
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= sw_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                sw_pkg::LOAD: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(LOAD_LAST)) begin
                        state <= sw_pkg::DRAIN;
                    end
                end
                sw_pkg::DRAIN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(DRAIN_LAST)) begin
                        state <= sw_pkg::SCAN;
                    end
                end
                sw_pkg::SCAN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(SCAN_LAST)) begin
                        state <= sw_pkg::DONE;
                    end
                end
                default: begin
                    if (start) begin
                        state <= sw_pkg::LOAD;
                        cnt   <= CNT_W'(1);
                    end else begin
                        state <= sw_pkg::IDLE;
                        cnt   <= '0;
                    end
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Capture stage, then feed stage into PE 0
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cap_valid  <= 1'b0;
            feed_valid <= 1'b0;
            clear      <= 1'b0;
        end else begin
            cap_valid  <= capture;
            feed_valid <= cap_valid;
            clear      <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            cap_query <= i_query_base;
            cap_idx   <= start ? '0 : sw_pkg::query_idx_t'(cnt);
        end
        feed_query <= cap_query;
        feed_idx   <= cap_idx;
        // Reference bank written straight from the input
        if (start) begin
            ref_bank[0] <= i_ref_base;
        end else if (state == sw_pkg::LOAD && cnt < `SW_REF_LEN) begin
            ref_bank[sw_pkg::ref_idx_t'(cnt)] <= i_ref_base;
        end
    end

    assign i_feed.feed_valid = feed_valid;
    assign i_feed.query_base = feed_query;
    assign i_feed.query_idx  = feed_idx;
    assign i_feed.ref_bases  = ref_bank;
    assign i_feed.clear      = clear;

    assign o_clear  = clear;
    assign o_scan   = (state == sw_pkg::SCAN);
    assign o_finish = (state == sw_pkg::DONE);

endmodule

// File: source/sw_pe.sv
// Systolic PE computing one cell of the affine-gap local alignment per cycle
`timescale 1ns/1ps
`include "sw_cfg.svh"

module sw_pe (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_clear,
    input  logic               i_valid,
    input  sw_pkg::base_t      i_query_base,
    input  sw_pkg::query_idx_t i_query_idx,
    input  sw_pkg::base_t      i_ref_base,
    input  sw_pkg::score_t     i_diag_align,
    input  sw_pkg::score_t     i_top_align,
    input  sw_pkg::score_t     i_top_insert,
    output logic               o_valid,
    output sw_pkg::base_t      o_query_base,
    output sw_pkg::query_idx_t o_query_idx,
    output sw_pkg::score_t     o_align,
    output sw_pkg::score_t     o_insert,
    output sw_pkg::score_t     o_align_prev
);

    localparam sw_pkg::score_t MATCH      = `SW_MATCH;
    localparam sw_pkg::score_t MISMATCH   = `SW_MISMATCH;
    localparam sw_pkg::score_t GAP_OPEN   = `SW_GAP_OPEN;
    localparam sw_pkg::score_t GAP_EXTEND = `SW_GAP_EXTEND;
    localparam sw_pkg::score_t BOUND_GAP  = -1;

    sw_pkg::score_t delete_q;
    sw_pkg::score_t subst;
    sw_pkg::score_t diag_sum;
    sw_pkg::score_t ins_open;
    sw_pkg::score_t ins_ext;
    sw_pkg::score_t del_open;
    sw_pkg::score_t del_ext;
    sw_pkg::score_t ins_nxt;
    sw_pkg::score_t del_nxt;
    sw_pkg::score_t align_nxt;

    always_comb begin
        subst    = (i_query_base == i_ref_base) ? MATCH : MISMATCH;
        diag_sum = i_diag_align + subst;
        // Insert from the neighbour, delete from this cell's previous row
        ins_open = i_top_align - GAP_OPEN;
        ins_ext  = i_top_insert - GAP_EXTEND;
        del_open = o_align - GAP_OPEN;
        del_ext  = delete_q - GAP_EXTEND;
        ins_nxt  = (ins_open > ins_ext) ? ins_open : ins_ext;
        del_nxt  = (del_open > del_ext) ? del_open : del_ext;
        align_nxt = diag_sum;
        if (ins_nxt > align_nxt) begin
            align_nxt = ins_nxt;
        end
        if (del_nxt > align_nxt) begin
            align_nxt = del_nxt;
        end
        if (align_nxt < 0) begin
            align_nxt = '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_valid      <= 1'b0;
            o_align      <= '0;
            o_insert     <= BOUND_GAP;
            delete_q     <= BOUND_GAP;
            o_align_prev <= '0;
        end else if (i_clear) begin
            o_valid      <= 1'b0;
            o_align      <= '0;
            o_insert     <= BOUND_GAP;
            delete_q     <= BOUND_GAP;
            o_align_prev <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_align      <= align_nxt;
                o_insert     <= ins_nxt;
                delete_q     <= del_nxt;
                o_align_prev <= o_align;
            end
        end
    end

    // Query base and index ride along with the row
    always_ff @(posedge clk) begin
        o_query_base <= i_query_base;
        o_query_idx  <= i_query_idx;
    end

endmodule

// File: source/sw_pe_array.sv
// Linear systolic array of PEs, one reference base per cell
`timescale 1ns/1ps
`include "sw_cfg.svh"

module sw_pe_array (
    input  logic      clk,
    input  logic      reset,
    sw_feed_if.array  i_feed,
    sw_score_if.array o_scores
);

    // First-row boundary seen by PE 0
    localparam sw_pkg::score_t BOUND_ALIGN = '0;
    localparam sw_pkg::score_t BOUND_GAP   = -1;

    logic               valid_c  [`SW_REF_LEN];
    sw_pkg::base_t      base_c   [`SW_REF_LEN];
    sw_pkg::query_idx_t idx_c    [`SW_REF_LEN];
    sw_pkg::score_t     align_c  [`SW_REF_LEN];
    sw_pkg::score_t     insert_c [`SW_REF_LEN];
    sw_pkg::score_t     prev_c   [`SW_REF_LEN];

    for (genvar j = 0; j < `SW_REF_LEN; j++) begin : g_cell
        logic               in_valid;
        sw_pkg::base_t      in_base;
        sw_pkg::query_idx_t in_idx;
        sw_pkg::score_t     top_align;
        sw_pkg::score_t     top_insert;
        sw_pkg::score_t     diag_align;

        if (j == 0) begin : g_head
            assign in_valid   = i_feed.feed_valid;
            assign in_base    = i_feed.query_base;
            assign in_idx     = i_feed.query_idx;
            assign top_align  = BOUND_ALIGN;
            assign top_insert = BOUND_GAP;
            assign diag_align = BOUND_ALIGN;
        end else begin : g_body
            assign in_valid   = valid_c[j-1];
            assign in_base    = base_c[j-1];
            assign in_idx     = idx_c[j-1];
            assign top_align  = align_c[j-1];
            assign top_insert = insert_c[j-1];
            assign diag_align = prev_c[j-1];
        end

        sw_pe u_pe (
            .clk          (clk),
            .reset        (reset),
            .i_clear      (i_feed.clear),
            .i_valid      (in_valid),
            .i_query_base (in_base),
            .i_query_idx  (in_idx),
            .i_ref_base   (i_feed.ref_bases[j]),
            .i_diag_align (diag_align),
            .i_top_align  (top_align),
            .i_top_insert (top_insert),
            .o_valid      (valid_c[j]),
            .o_query_base (base_c[j]),
            .o_query_idx  (idx_c[j]),
            .o_align      (align_c[j]),
            .o_insert     (insert_c[j]),
            .o_align_prev (prev_c[j])
        );

        assign o_scores.align[j]     = align_c[j];
        assign o_scores.valid[j]     = valid_c[j];
        assign o_scores.query_idx[j] = idx_c[j];
    end

endmodule

// File: source/sw_max_tracker.sv
// Max tracker: per-PE best score with its query row, then a scan for the overall best
`timescale 1ns/1ps
`include "sw_cfg.svh"

module sw_max_tracker (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  i_clear,
    input  logic                                  i_scan,
    sw_score_if.tracker                           i_scores,
    output sw_pkg::score_t                        o_max,
    output logic [$bits(sw_pkg::ref_idx_t):0]     o_pos_ref,
    output logic [$bits(sw_pkg::query_idx_t):0]   o_pos_query
);

    localparam sw_pkg::ref_idx_t LAST_PE = sw_pkg::ref_idx_t'(`SW_REF_LEN - 1);

    sw_pkg::score_t     col_best [`SW_REF_LEN];
    sw_pkg::query_idx_t col_qidx [`SW_REF_LEN];
    sw_pkg::ref_idx_t   ptr;
    sw_pkg::score_t     best_score;
    sw_pkg::ref_idx_t   best_ref;
    sw_pkg::query_idx_t best_qidx;
    sw_pkg::score_t     nxt_score;
    sw_pkg::ref_idx_t   nxt_ref;
    sw_pkg::query_idx_t nxt_qidx;
    logic               take;

    // ------------------------------------------------------------------
    // Running best per PE, strict compare keeps the earliest row
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int j = 0; j < `SW_REF_LEN; j++) begin
            if (i_clear) begin
                col_best[j] <= '0;
                col_qidx[j] <= '0;
            end else if (i_scores.valid[j] && i_scores.align[j] > col_best[j]) begin
                col_best[j] <= i_scores.align[j];
                col_qidx[j] <= i_scores.query_idx[j];
            end
        end
    end

    // ------------------------------------------------------------------
    // Scan over PEs in ascending order
    // ------------------------------------------------------------------
    assign take      = i_scan && (col_best[ptr] > best_score);
    assign nxt_score = take ? col_best[ptr] : best_score;
    assign nxt_ref   = take ? ptr : best_ref;
    assign nxt_qidx  = take ? col_qidx[ptr] : best_qidx;

    always_ff @(posedge clk) begin
        if (i_clear) begin
            best_score <= '0;
            best_ref   <= '0;
            best_qidx  <= '0;
        end else if (i_scan) begin
            best_score <= nxt_score;
            best_ref   <= nxt_ref;
            best_qidx  <= nxt_qidx;
        end
    end

    // Results held until the next scan completes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ptr         <= '0;
            o_max       <= '0;
            o_pos_ref   <= '0;
            o_pos_query <= '0;
        end else begin
            ptr <= i_scan ? ptr + 1'b1 : '0;
            if (i_scan && ptr == LAST_PE) begin
                o_max       <= nxt_score;
                o_pos_ref   <= {1'b0, nxt_ref} + 1'b1;
                o_pos_query <= {1'b0, nxt_qidx} + 1'b1;
            end
        end
    end

endmodule

// File: source/sw_top.sv
// Smith-Waterman local alignment engine top level with plain strobe ports
`timescale 1ns/1ps

module sw_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                i_valid,
    input  sw_pkg::base_t                       i_ref_base,
    input  sw_pkg::base_t                       i_query_base,
    output logic                                o_finish,
    output sw_pkg::score_t                      o_max,
    output logic [$bits(sw_pkg::ref_idx_t):0]   o_pos_ref,
    output logic [$bits(sw_pkg::query_idx_t):0] o_pos_query
);

    logic clear;
    logic scan;

    sw_feed_if  feed_if ();
    sw_score_if score_if ();

    sw_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .i_valid      (i_valid),
        .i_ref_base   (i_ref_base),
        .i_query_base (i_query_base),
        .i_feed       (feed_if.sequencer),
        .o_clear      (clear),
        .o_scan       (scan),
        .o_finish     (o_finish)
    );

    sw_pe_array u_pe_array (
        .clk      (clk),
        .reset    (reset),
        .i_feed   (feed_if.array),
        .o_scores (score_if.array)
    );

    sw_max_tracker u_max_tracker (
        .clk         (clk),
        .reset       (reset),
        .i_clear     (clear),
        .i_scan      (scan),
        .i_scores    (score_if.tracker),
        .o_max       (o_max),
        .o_pos_ref   (o_pos_ref),
        .o_pos_query (o_pos_query)
    );

endmodule

// File: verification/sw_tb.sv
// Testbench running directed and random Smith-Waterman alignments against a reference model
`timescale 1ns/1ps
`include "sw_cfg.svh"

module sw_tb;

    localparam int REF_LEN     = `SW_REF_LEN;
    localparam int QUERY_LEN   = `SW_QUERY_LEN;
    localparam int LATENCY     = `SW_LATENCY;
    localparam int NUM_TESTS   = 25;
    localparam int CYCLE_LIMIT = NUM_TESTS * (LATENCY + 4) + 20;
    localparam int SEED        = 31324;
    // Gapped-run reference with two bits per base and base 0 in the low bits
    localparam logic [31:0] GAP_REF = 32'h729C1BE4;

    typedef logic [$bits(sw_pkg::ref_idx_t):0]   ref_pos_t;
    typedef logic [$bits(sw_pkg::query_idx_t):0] query_pos_t;

    logic           clk;
    logic           reset;
    logic           i_valid;
    sw_pkg::base_t  i_ref_base;
    sw_pkg::base_t  i_query_base;
    logic           o_finish;
    sw_pkg::score_t o_max;
    ref_pos_t       o_pos_ref;
    query_pos_t     o_pos_query;

    sw_pkg::base_t  ref_seq [REF_LEN];
    sw_pkg::base_t  qry_seq [QUERY_LEN];
    int             h_m   [0:QUERY_LEN][0:REF_LEN];
    int             ins_m [0:QUERY_LEN][0:REF_LEN];
    int             del_m [0:QUERY_LEN][0:REF_LEN];

    int             cycle;
    int             start_cycle;
    bit             pending;
    int             errors;
    int             errors_at_start;
    int             test_num;
    int             tests_failed;
    string          test_name;
    sw_pkg::score_t exp_score;
    ref_pos_t       exp_ref;
    query_pos_t     exp_query;

    sw_top sw_top_inst (
        .clk          (clk),
        .reset        (reset),
        .i_valid      (i_valid),
        .i_ref_base   (i_ref_base),
        .i_query_base (i_query_base),
        .o_finish     (o_finish),
        .o_max        (o_max),
        .o_pos_ref    (o_pos_ref),
        .o_pos_query  (o_pos_query)
    );

    always #50 clk = ~clk;

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic int max2(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    // ------------------------------------------------------------------
    // Reference model over the full H/I/D matrices
    // ------------------------------------------------------------------
    function automatic void sw_model(output sw_pkg::score_t best, output ref_pos_t pos_r,
                                     output query_pos_t pos_q);
        int s;
        int h;
        int best_i;
        best_i = 0;
        pos_r  = 1;
        pos_q  = 1;
        for (int j = 0; j <= REF_LEN; j++) begin
            h_m[0][j]   = 0;
            ins_m[0][j] = -1;
            del_m[0][j] = -1;
        end
        for (int i = 0; i <= QUERY_LEN; i++) begin
            h_m[i][0]   = 0;
            ins_m[i][0] = -1;
            del_m[i][0] = -1;
        end
        for (int i = 1; i <= QUERY_LEN; i++) begin
            for (int j = 1; j <= REF_LEN; j++) begin
                s = (qry_seq[i-1] == ref_seq[j-1]) ? `SW_MATCH : `SW_MISMATCH;
                ins_m[i][j] = max2(h_m[i][j-1] - `SW_GAP_OPEN, ins_m[i][j-1] - `SW_GAP_EXTEND);
                del_m[i][j] = max2(h_m[i-1][j] - `SW_GAP_OPEN, del_m[i-1][j] - `SW_GAP_EXTEND);
                h = max2(0, h_m[i-1][j-1] + s);
                h = max2(h, ins_m[i][j]);
                h_m[i][j] = max2(h, del_m[i][j]);
            end
        end
        // Lowest reference column first and then earliest query row
        for (int j = 1; j <= REF_LEN; j++) begin
            for (int i = 1; i <= QUERY_LEN; i++) begin
                if (h_m[i][j] > best_i) begin
                    best_i = h_m[i][j];
                    pos_r  = ref_pos_t'(j);
                    pos_q  = query_pos_t'(i);
                end
            end
        end
        best = sw_pkg::score_t'(best_i);
    endfunction

    task automatic check_score(input string name, input sw_pkg::score_t got,
                               input sw_pkg::score_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_pos(input ref_pos_t got_ref, input ref_pos_t want_ref,
                             input query_pos_t got_query, input query_pos_t want_query);
        if (got_ref !== want_ref) begin
            $display("Mismatch o_pos_ref: got 0x%h, expected 0x%h", got_ref, want_ref);
            errors++;
        end
        if (got_query !== want_query) begin
            $display("Mismatch o_pos_query: got 0x%h, expected 0x%h", got_query, want_query);
            errors++;
        end
    endtask

    task automatic report_test();
        test_num++;
        if (errors == errors_at_start) begin
            $display("Test %0d %s: ok", test_num, test_name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed, %0d errors", test_num, test_name,
                     errors - errors_at_start);
        end
    endtask

    // ------------------------------------------------------------------
    // Result checker sampling outputs on the falling edge
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (o_finish) begin
            if (!pending) begin
                $display("o_finish pulsed with no run in progress at cycle %0d", cycle);
                errors++;
            end else begin
                if (cycle - start_cycle != LATENCY) begin
                    $display("%s: o_finish came %0d cycles after i_valid instead of %0d",
                             test_name, cycle - start_cycle, LATENCY);
                    errors++;
                end
                check_score("o_max", o_max, exp_score);
                check_pos(o_pos_ref, exp_ref, o_pos_query, exp_query);
                report_test();
                pending = 1'b0;
            end
        end else if (pending && cycle - start_cycle > LATENCY) begin
            $display("%s: o_finish missing %0d cycles after i_valid", test_name, LATENCY);
            errors++;
            report_test();
            pending = 1'b0;
        end
    end

    // Starts on a falling edge and returns on the edge that shows o_finish
    task automatic run_test(input string name, input bit noise);
        sw_model(exp_score, exp_ref, exp_query);
        test_name       = name;
        errors_at_start = errors;
        start_cycle     = cycle;
        pending         = 1'b1;
        for (int k = 0; k < QUERY_LEN; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            i_valid      = (k == 0) || (noise && (k == 3 || k == 20));
            i_ref_base   = (k < REF_LEN) ? ref_seq[k] : 2'd0;
            i_query_base = qry_seq[k];
        end
        // Stray pulses land in DRAIN and SCAN
        for (int w = 1; w <= 31; w++) begin
            @(negedge clk);
            i_valid      = noise && (w == 10 || w == 30);
            i_ref_base   = '0;
            i_query_base = '0;
        end
        wait (!pending);
    endtask

    task automatic fill_random();
        for (int k = 0; k < REF_LEN; k++) begin
            ref_seq[k] = sw_pkg::base_t'($urandom);
        end
        for (int k = 0; k < QUERY_LEN; k++) begin
            qry_seq[k] = sw_pkg::base_t'($urandom);
        end
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        i_valid         = 1'b0;
        i_ref_base      = '0;
        i_query_base    = '0;
        cycle           = 0;
        start_cycle     = 0;
        pending         = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        test_num        = 0;
        tests_failed    = 0;
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_name       = "idle after reset";
        errors_at_start = errors;
        repeat (2 * REF_LEN) begin
            @(negedge clk);
            check_score("o_max", o_max, '0);
            check_pos(o_pos_ref, '0, o_pos_query, '0);
        end
        report_test();

        // Whole reference inside the query with random flanks
        fill_random();
        for (int k = 0; k < REF_LEN; k++) begin
            qry_seq[k + 4] = ref_seq[k];
        end
        run_test("exact reference in query", 1'b0);

        // No base pair matches
        for (int k = 0; k < REF_LEN; k++) begin
            ref_seq[k] = sw_pkg::base_t'($urandom % 2);
        end
        for (int k = 0; k < QUERY_LEN; k++) begin
            qry_seq[k] = sw_pkg::base_t'(2 + $urandom % 2);
        end
        run_test("complement query", 1'b0);

        // One inserted base, then reference base 12 left out
        for (int k = 0; k < REF_LEN; k++) begin
            ref_seq[k] = GAP_REF[2*k +: 2];
        end
        for (int k = 0; k < 8; k++) begin
            qry_seq[k] = ref_seq[k];
        end
        qry_seq[8] = 2'd2;
        for (int k = 8; k < 12; k++) begin
            qry_seq[k + 1] = ref_seq[k];
        end
        for (int k = 13; k < REF_LEN; k++) begin
            qry_seq[k] = ref_seq[k];
        end
        for (int k = REF_LEN; k < QUERY_LEN; k++) begin
            qry_seq[k] = 2'd1;
        end
        run_test("insertion and deletion", 1'b0);

        for (int n = 0; n < 20; n++) begin
            fill_random();
            run_test($sformatf("random pair %0d", n), 1'b0);
        end

        fill_random();
        run_test("stray i_valid pulses", 1'b1);

        repeat (4) @(negedge clk);
        $display("%0d tests, %0d passed, %0d failed, %0d errors", test_num,
                 test_num - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
source/sw_pkg.sv
source/sw_feed_if.sv
source/sw_score_if.sv
source/sw_sequencer.sv
source/sw_pe.sv
source/sw_pe_array.sv
source/sw_max_tracker.sv
source/sw_top.sv
verification/sw_tb.sv

// File: Bender.yml
package:
  name: sw_engine

sources:
  - include_dirs:
      - include
    files:
      - source/sw_pkg.sv
      - source/sw_feed_if.sv
      - source/sw_score_if.sv
      - source/sw_sequencer.sv
      - source/sw_pe.sv
      - source/sw_pe_array.sv
      - source/sw_max_tracker.sv
      - source/sw_top.sv
      - target: test
        files:
          - verification/sw_tb.sv
